// File: common/burst_pkg.sv
package burst_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------

  // Transaction ID, one remaining-beat counter per value
  localparam int unsigned ID_WIDTH   = 2;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned NUM_IDS    = 2 ** ID_WIDTH;

  typedef logic [ID_WIDTH-1:0]   id_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // AXI burst length, number of beats minus one
  typedef logic [7:0] len_t;

  // Remaining beats of a burst, holds len + 1 up to 256
  typedef logic [8:0] cnt_t;

  // ----------------------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------------------

  // AXI AxBURST values, WRAP is listed for the encoding only
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // AR splitter FSM
  typedef enum logic {
    AR_IDLE,
    AR_BUSY
  } ar_state_e;

  // R path FSM
  typedef enum logic {
    R_FEED,
    R_WAIT
  } r_state_e;

  // ----------------------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------------------

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    burst_e     burst;
  } ar_req_t;

  typedef struct packed {
    id_t        id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
  } r_beat_t;

endpackage

// File: ar_split/ar_splitter.sv
`timescale 1ns/1ns

module ar_splitter import burst_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,

  // Upstream AR, bursts
  input  ar_req_t up_ar_i,
  input  logic    up_ar_valid_i,
  output logic    up_ar_ready_o,

  // Downstream AR, single beats
  output ar_req_t dn_ar_o,
  output logic    dn_ar_valid_o,
  input  logic    dn_ar_ready_i,

  // Counter allocation
  input  logic    alloc_ok_i,
  output logic    alloc_valid_o,
  output id_t     alloc_id_o,
  output len_t    alloc_len_o
);

  ar_state_e state_d, state_q;
  ar_req_t   ax_d, ax_q;

  // Address of the following beat
  function automatic addr_t next_addr(ar_req_t ax);
    if (ax.burst == BURST_INCR) begin
      return ax.addr + (ADDR_WIDTH'(1) << ax.size);
    end
    return ax.addr;
  endfunction

  assign alloc_id_o  = up_ar_i.id;
  assign alloc_len_o = up_ar_i.len;

  always_comb begin
    state_d       = state_q;
    ax_d          = ax_q;
    up_ar_ready_o = 1'b0;
    alloc_valid_o = 1'b0;
    dn_ar_o       = up_ar_i;
    dn_ar_o.len   = '0;
    dn_ar_valid_o = 1'b0;

    unique case (state_q)
      AR_IDLE: begin
        if (up_ar_valid_i && alloc_ok_i) begin
          dn_ar_valid_o = 1'b1;
          if (up_ar_i.len == '0) begin
            // Single beat already, pass through and ack once downstream takes it
            if (dn_ar_ready_i) begin
              up_ar_ready_o = 1'b1;
              alloc_valid_o = 1'b1;
            end
          end else begin
            // Take the burst now and offer its first beat in the same cycle
            up_ar_ready_o = 1'b1;
            alloc_valid_o = 1'b1;
            ax_d          = up_ar_i;
            if (dn_ar_ready_i) begin
              ax_d.len  = up_ar_i.len - 8'd1;
              ax_d.addr = next_addr(up_ar_i);
            end
            state_d = AR_BUSY;
          end
        end
      end

      AR_BUSY: begin
        // len in the register counts the beats still to go after this one
        dn_ar_o       = ax_q;
        dn_ar_o.len   = '0;
        dn_ar_valid_o = 1'b1;
        if (dn_ar_ready_i) begin
          if (ax_q.len == '0) begin
            state_d = AR_IDLE;
          end else begin
            ax_d.len  = ax_q.len - 8'd1;
            ax_d.addr = next_addr(ax_q);
          end
        end
      end

      default: begin
        state_d = AR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= AR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Burst register
  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  a_single_beat: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dn_ar_valid_o |-> dn_ar_o.len == '0
  ) else $error("multi-beat request sent downstream");

  // A stalled single beat stays on the bus unchanged
  a_dn_ar_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dn_ar_valid_o && !dn_ar_ready_i |=> dn_ar_valid_o && $stable(dn_ar_o)
  ) else $error("downstream AR changed under back-pressure");

endmodule

// File: ar_split/burst_counters.sv
`timescale 1ns/1ns

module burst_counters import burst_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,

  // Allocation from the AR side
  input  logic alloc_valid_i,
  input  id_t  alloc_id_i,
  input  len_t alloc_len_i,
  output logic alloc_ok_o,

  // Lookup and decrement from the R side
  input  id_t  cnt_id_i,
  input  logic cnt_dec_i,
  output logic cnt_last_o,
  output logic cnt_busy_o
);

  cnt_t cnt_q [NUM_IDS];
  cnt_t alloc_cnt;
  cnt_t lookup_cnt;

  // A burst of len beats minus one keeps len + 1 beats outstanding
  assign alloc_cnt  = cnt_t'({1'b0, alloc_len_i}) + cnt_t'(1);
  assign lookup_cnt = cnt_q[cnt_id_i];

  // One burst per ID, so a new one only starts on an empty counter
  assign alloc_ok_o = (cnt_q[alloc_id_i] == '0);
  assign cnt_busy_o = (lookup_cnt != '0);
  assign cnt_last_o = (lookup_cnt == cnt_t'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        if (alloc_valid_i && alloc_id_i == id_t'(i)) begin
          cnt_q[i] <= alloc_cnt;
        end else if (cnt_dec_i && cnt_id_i == id_t'(i)) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // The AR side must wait for alloc_ok before it allocates
  a_alloc_free: assert property (
    @(posedge clk_i) disable iff (reset_i)
    alloc_valid_i |-> cnt_q[alloc_id_i] == '0
  ) else $error("allocation on a busy counter");

  // R beats only come back for bursts that were sent
  a_dec_busy: assert property (
    @(posedge clk_i) disable iff (reset_i)
    cnt_dec_i |-> cnt_q[cnt_id_i] != '0
  ) else $error("decrement of an empty counter");

endmodule

// File: logic/r_last_restore.sv
`timescale 1ns/1ns

module r_last_restore import burst_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,

  // Downstream R, single beats
  input  r_beat_t dn_r_i,
  input  logic    dn_r_valid_i,
  output logic    dn_r_ready_o,

  // Upstream R, with rebuilt last
  output r_beat_t up_r_o,
  output logic    up_r_valid_o,
  input  logic    up_r_ready_i,

  // Counter lookup
  output id_t     cnt_id_o,
  output logic    cnt_dec_o,
  input  logic    cnt_last_i,
  input  logic    cnt_busy_i
);

  r_state_e state_d, state_q;
  logic     last_d, last_q;

  assign cnt_id_o = dn_r_i.id;

  always_comb begin
    state_d      = state_q;
    last_d       = last_q;
    dn_r_ready_o = 1'b0;
    up_r_valid_o = 1'b0;
    cnt_dec_o    = 1'b0;
    up_r_o       = dn_r_i;
    up_r_o.last  = cnt_last_i;

    unique case (state_q)
      R_FEED: begin
        if (dn_r_valid_i && cnt_busy_i) begin
          // Count the beat now, the counter moves on at the next edge
          up_r_valid_o = 1'b1;
          cnt_dec_o    = 1'b1;
          if (up_r_ready_i) begin
            dn_r_ready_o = 1'b1;
          end else begin
            last_d  = cnt_last_i;
            state_d = R_WAIT;
          end
        end
      end

      R_WAIT: begin
        // Counter is already decremented, so last comes from the register
        up_r_o.last  = last_q;
        up_r_valid_o = dn_r_valid_i;
        if (dn_r_valid_i && up_r_ready_i) begin
          dn_r_ready_o = 1'b1;
          state_d      = R_FEED;
        end
      end

      default: begin
        state_d = R_FEED;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= R_FEED;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

  // A new downstream beat belongs to a burst that is still open
  a_r_has_burst: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dn_r_valid_i && state_q == R_FEED |-> cnt_busy_i
  ) else $error("R beat for an ID with no open burst");

endmodule

// File: logic/burst_splitter_top.sv
`timescale 1ns/1ns

module burst_splitter_top import burst_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,

  input  ar_req_t up_ar_i,
  input  logic    up_ar_valid_i,
  output logic    up_ar_ready_o,

  output ar_req_t dn_ar_o,
  output logic    dn_ar_valid_o,
  input  logic    dn_ar_ready_i,

  input  r_beat_t dn_r_i,
  input  logic    dn_r_valid_i,
  output logic    dn_r_ready_o,

  output r_beat_t up_r_o,
  output logic    up_r_valid_o,
  input  logic    up_r_ready_i
);

  // Allocation, AR side to counters
  logic alloc_valid;
  logic alloc_ok;
  id_t  alloc_id;
  len_t alloc_len;

  // Lookup, R side to counters
  id_t  cnt_id;
  logic cnt_dec;
  logic cnt_last;
  logic cnt_busy;

  ar_splitter ar_splitter_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .up_ar_i       (up_ar_i),
    .up_ar_valid_i (up_ar_valid_i),
    .up_ar_ready_o (up_ar_ready_o),
    .dn_ar_o       (dn_ar_o),
    .dn_ar_valid_o (dn_ar_valid_o),
    .dn_ar_ready_i (dn_ar_ready_i),
    .alloc_ok_i    (alloc_ok),
    .alloc_valid_o (alloc_valid),
    .alloc_id_o    (alloc_id),
    .alloc_len_o   (alloc_len)
  );

  burst_counters burst_counters_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .alloc_valid_i (alloc_valid),
    .alloc_id_i    (alloc_id),
    .alloc_len_i   (alloc_len),
    .alloc_ok_o    (alloc_ok),
    .cnt_id_i      (cnt_id),
    .cnt_dec_i     (cnt_dec),
    .cnt_last_o    (cnt_last),
    .cnt_busy_o    (cnt_busy)
  );

  r_last_restore r_last_restore_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .dn_r_i       (dn_r_i),
    .dn_r_valid_i (dn_r_valid_i),
    .dn_r_ready_o (dn_r_ready_o),
    .up_r_o       (up_r_o),
    .up_r_valid_o (up_r_valid_o),
    .up_r_ready_i (up_r_ready_i),
    .cnt_id_o     (cnt_id),
    .cnt_dec_o    (cnt_dec),
    .cnt_last_i   (cnt_last),
    .cnt_busy_i   (cnt_busy)
  );

endmodule

// File: verification/single_beat_responder.sv
`timescale 1ns/1ns

module single_beat_responder import burst_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,

  // Random pacing from the testbench
  input  logic    accept_i,
  input  logic    offer_i,

  // Single-beat AR from the DUT
  input  ar_req_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,

  // R beats back to the DUT
  output r_beat_t r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  // Requests taken but not answered yet, oldest first
  ar_req_t pending [$];

  logic    ar_ready_q = 1'b0;
  logic    r_valid_q  = 1'b0;
  r_beat_t r_q        = '0;

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = r_valid_q;
  assign r_o        = r_q;

  always @(posedge clk_i) begin
    ar_req_t head;
    if (reset_i) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      pending.delete();
    end else begin
      if (ar_valid_i && ar_ready_q) begin
        pending.push_back(ar_i);
      end
      ar_ready_q <= accept_i;

      // A beat on the bus stays until the DUT takes it
      if (!r_valid_q || r_ready_i) begin
        if (offer_i && pending.size() != 0) begin
          head      = pending.pop_front();
          r_q.id    <= head.id;
          r_q.data  <= head.addr;
          r_q.resp  <= 2'b00;  // OKAY
          r_q.last  <= 1'b1;
          r_valid_q <= 1'b1;
        end else begin
          r_valid_q <= 1'b0;
        end
      end
    end
  end

endmodule

// File: verification/tb_burst_splitter.sv
`timescale 1ns/1ns

module tb_burst_splitter import burst_pkg::*; ();

  localparam int NUM_ROWS = 9;

  logic        clk = 1'b0;
  logic        reset;
  ar_req_t     up_ar;
  logic        up_ar_valid;
  logic        up_ar_ready;
  ar_req_t     dn_ar;
  logic        dn_ar_valid;
  logic        dn_ar_ready;
  r_beat_t     dn_r;
  logic        dn_r_valid;
  logic        dn_r_ready;
  r_beat_t     up_r;
  logic        up_r_valid;
  logic        up_r_ready = 1'b0;
  logic        accept     = 1'b0;
  logic        offer      = 1'b0;
  logic [31:0] rng        = 32'hf659cf79;

  // Stimulus table, position of the checkers in it, and the ID owners
  ar_req_t rows [NUM_ROWS];
  int      r_total = 0;
  int      ar_row, ar_beat, r_row, r_beat;
  int      open_row [NUM_IDS];
  int      errors  = 0;
  int      ar_seen = 0;
  int      r_seen  = 0;

  burst_splitter_top dut_i (
    .clk_i (clk), .reset_i (reset),
    .up_ar_i (up_ar), .up_ar_valid_i (up_ar_valid), .up_ar_ready_o (up_ar_ready),
    .dn_ar_o (dn_ar), .dn_ar_valid_o (dn_ar_valid), .dn_ar_ready_i (dn_ar_ready),
    .dn_r_i (dn_r), .dn_r_valid_i (dn_r_valid), .dn_r_ready_o (dn_r_ready),
    .up_r_o (up_r), .up_r_valid_o (up_r_valid), .up_r_ready_i (up_r_ready)
  );

  single_beat_responder responder_i (
    .clk_i (clk), .reset_i (reset), .accept_i (accept), .offer_i (offer),
    .ar_i (dn_ar), .ar_valid_i (dn_ar_valid), .ar_ready_o (dn_ar_ready),
    .r_o (dn_r), .r_valid_o (dn_r_valid), .r_ready_i (dn_r_ready)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Address of beat k of a burst
  function automatic addr_t beat_addr(input ar_req_t req, input int k);
    if (req.burst == BURST_INCR) begin
      return req.addr + (addr_t'(k) << req.size);
    end
    return req.addr;
  endfunction

  // Back-pressure on downstream AR, R and upstream R
  always @(posedge clk) begin
    rng = xorshift32(rng);
    accept     <= rng[1:0] != 2'b00;
    offer      <= rng[9:8] != 2'b00;
    up_r_ready <= rng[17:16] != 2'b00;
  end

  // ----------------------------------------------------------------------
  // Checkers that follow table order on both channels
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    ar_req_t want_ar;
    r_beat_t want_r;
    int      i;
    if (reset) begin
      for (i = 0; i < NUM_IDS; i++) begin
        open_row[i] = -1;
      end
      ar_row  = 0;
      ar_beat = 0;
      r_row   = 0;
      r_beat  = 0;
    end else begin
      // A burst is taken together with the offer of its first single beat
      if (up_ar_valid && up_ar_ready) begin
        if (!dn_ar_valid || (up_ar.len == '0 && !dn_ar_ready)) begin
          $display("%0t: burst accepted upstream without its first beat downstream", $time);
          errors++;
        end
      end
      if (dn_ar_valid && dn_ar_ready) begin
        ar_seen++;
        if (ar_row >= NUM_ROWS) begin
          $display("%0t: downstream request after every burst was split", $time);
          errors++;
        end else begin
          want_ar      = rows[ar_row];
          want_ar.addr = beat_addr(rows[ar_row], ar_beat);
          want_ar.len  = '0;
          if (dn_ar !== want_ar) begin
            $display("FAILED %0t dn_ar_o expected %h got %h", $time, want_ar, dn_ar);
            errors++;
          end
          // A busy ID holds back the next burst
          if (open_row[want_ar.id] != -1 && open_row[want_ar.id] != ar_row) begin
            $display("%0t: row %0d went downstream while row %0d on its ID was open",
                     $time, ar_row, open_row[want_ar.id]);
            errors++;
          end
          open_row[want_ar.id] = ar_row;
          if (ar_beat == int'(rows[ar_row].len)) begin
            ar_row++;
            ar_beat = 0;
          end else begin
            ar_beat++;
          end
        end
      end
      // The ID is free once the final beat of its burst is offered upstream
      if (up_r_valid && r_row < NUM_ROWS && r_beat == int'(rows[r_row].len) &&
          open_row[rows[r_row].id] == r_row) begin
        open_row[rows[r_row].id] = -1;
      end
      if (up_r_valid && up_r_ready) begin
        r_seen++;
        if (r_row >= NUM_ROWS) begin
          $display("%0t: upstream R beat after every burst completed", $time);
          errors++;
        end else begin
          want_r.id   = rows[r_row].id;
          want_r.data = beat_addr(rows[r_row], r_beat);
          want_r.resp = 2'b00;
          want_r.last = (r_beat == int'(rows[r_row].len));
          if (up_r !== want_r) begin
            $display("FAILED %0t up_r_o expected %h got %h", $time, want_r, up_r);
            errors++;
          end
          if (want_r.last) begin
            r_row++;
            r_beat = 0;
          end else begin
            r_beat++;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    int r;
    up_ar       = '0;
    up_ar_valid = 1'b0;
    reset       = 1'b1;
    // Rows 2 and 6 reuse the ID of the burst just before them
    rows[0] = '{id: 2'd0, addr: 32'h0000_1000, len: 8'd0,   size: 3'd2, burst: BURST_INCR};
    rows[1] = '{id: 2'd1, addr: 32'h0000_2000, len: 8'd3,   size: 3'd2, burst: BURST_INCR};
    rows[2] = '{id: 2'd1, addr: 32'h0000_3000, len: 8'd1,   size: 3'd2, burst: BURST_INCR};
    rows[3] = '{id: 2'd2, addr: 32'h0000_4004, len: 8'd4,   size: 3'd0, burst: BURST_FIXED};
    rows[4] = '{id: 2'd3, addr: 32'h0000_5000, len: 8'd7,   size: 3'd3, burst: BURST_INCR};
    rows[5] = '{id: 2'd0, addr: 32'h0000_6010, len: 8'd0,   size: 3'd2, burst: BURST_FIXED};
    rows[6] = '{id: 2'd0, addr: 32'h0000_7000, len: 8'd15,  size: 3'd1, burst: BURST_INCR};
    rows[7] = '{id: 2'd2, addr: 32'h0000_8ffc, len: 8'd2,   size: 3'd2, burst: BURST_INCR};
    rows[8] = '{id: 2'd3, addr: 32'h0001_0000, len: 8'd255, size: 3'd2, burst: BURST_INCR};
    for (r = 0; r < NUM_ROWS; r++) begin
      r_total += int'(rows[r].len) + 1;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (r = 0; r < NUM_ROWS; r++) begin
      up_ar       <= rows[r];
      up_ar_valid <= 1'b1;
      @(posedge clk);
      while (!up_ar_ready) begin
        @(posedge clk);
      end
    end
    up_ar_valid <= 1'b0;
    while (r_seen < r_total) begin
      @(posedge clk);
    end
    // Room for stray beats
    repeat (20) @(posedge clk);
    $display("errors: %0d, requests: %0d of %0d, R beats: %0d of %0d",
             errors, ar_seen, r_total, r_seen, r_total);
    if (errors == 0 && ar_seen == r_total && r_seen == r_total) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_ROWS * 200) @(posedge clk);
    $display("timeout: only %0d of %0d R beats returned, errors: %0d", r_seen, r_total, errors);
    $display("test failed");
    $finish;
  end

endmodule

// File: project.f
common/burst_pkg.sv
ar_split/ar_splitter.sv
ar_split/burst_counters.sv
logic/r_last_restore.sv
logic/burst_splitter_top.sv
verification/single_beat_responder.sv
verification/tb_burst_splitter.sv

// File: Makefile
# Verilator build and run of the burst splitter testbench

SIM  := obj_dir/Vtb_burst_splitter
SRCS := $(wildcard common/*.sv ar_split/*.sv logic/*.sv verification/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) project.f
	verilator --binary --timing --assert -j 0 --top-module tb_burst_splitter -f project.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
